// File: files.f
verilog/procIsaPkg.sv
verilog/procPipePkg.sv
verilog/fetch.sv
verilog/decode.sv
verilog/regFile.sv
verilog/execute.sv
verilog/memoryStage.sv
verilog/proc.sv
test/procChecker.sv
test/procTb.sv

// File: run.sh
#!/bin/sh
# Builds procTb with Verilator, runs it into sim.log and checks the log for the pass message
cd "$(dirname "$0")" &&
rm -f sim.log &&
verilator --binary --timing -f files.f --top-module procTb -o procSim &&
./obj_dir/procSim | tee sim.log &&
grep -q "TB PASSED" sim.log &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }

// File: test/procChecker.sv
// Checker for procTb: compares each commit and the final status flags with the golden trace
// Samples on the falling clock edge and prints one line per finished test
`timescale 1ns/100ps
module procChecker
    import procIsaPkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  logic    wbValid,
    input  regAddrT wbAddr,
    input  wordT    wbData,
    input  logic    halted,
    input  logic    err,
    input  int      phase,
    input  logic    phaseDone,          // One-cycle pulse, closes the phase
    input  wordT    golden [imemDepth],
    output int      testsRun,
    output int      testsPassed,
    output int      testsFailed
);

    int   base;
    int   traceLen;
    int   traceStart;
    wordT flags;                        // bit0 halted, bit1 err
    int   idx;                          // Next trace row
    int   curTest;
    int   curErrs;
    int   extraCommits;
    int   lateCommits;
    logic errEverHigh;
    logic errDropped;
    int   runCount = 0;
    int   passCount = 0;
    int   failCount = 0;

    assign base = phase * (imemDepth / 2);
    assign traceLen = int'(golden[base + 1]);
    assign flags = golden[base + 2];
    assign traceStart = base + 3 + int'(golden[base]);   // Rows come after the program
    assign testsRun = runCount;
    assign testsPassed = passCount;
    assign testsFailed = failCount;

    function automatic string testName(input int id);
        case (id)
            1: return "immediates";
            2: return "register ALU";
            3: return "store and load";
            4: return "branches and jumps";
            6: return "illegal opcode program";
            default: return "unnamed";
        endcase
    endfunction

    task automatic reportTest(input string name, input int errs);
        runCount++;
        if (errs == 0) begin
            passCount++;
            $display("Test %s: passed", name);
        end else begin
            failCount++;
            $display("Test %s: failed with %0d errors", name, errs);
        end
    endtask

    task automatic checkCommit();
        int      entry;
        int      testId;
        regAddrT expAddr;
        wordT    expData;
        entry = traceStart + 3 * idx;
        if (halted) begin
            lateCommits++;
            $display("Commit to r%0d at %0d ns after halted was raised", wbAddr, $time);
        end
        if (idx >= traceLen) begin
            extraCommits++;
            $display("Unexpected commit at %0d ns, r%0d = 0x%h past the end of the trace",
                     $time, wbAddr, wbData);
        end else begin
            testId = int'(golden[entry]);
            expAddr = regAddrT'(golden[entry + 1]);
            expData = golden[entry + 2];
            if (testId != curTest) begin  // Previous test has no rows left
                if (curTest != 0) begin
                    reportTest(testName(curTest), curErrs);
                end
                curTest = testId;
                curErrs = 0;
            end
            if (wbAddr !== expAddr) begin
                $display("FAILED at %0d ns: wbAddr expected %0d, actual %0d",
                         $time, expAddr, wbAddr);
                curErrs++;
            end
            if (wbData !== expData) begin
                $display("FAILED at %0d ns: wbData expected 0x%h, actual 0x%h",
                         $time, expData, wbData);
                curErrs++;
            end
            idx++;
        end
    endtask

    task automatic closePhase();
        int haltErrs;
        int errErrs;
        haltErrs = extraCommits + lateCommits;   // Already reported one by one
        errErrs = 0;
        if (curTest != 0) begin
            reportTest(testName(curTest), curErrs);
            curTest = 0;
        end
        if (halted !== flags[0]) begin
            $display("FAILED at %0d ns: halted expected %0b, actual %0b", $time, flags[0], halted);
            haltErrs++;
        end
        if (idx != traceLen) begin
            $display("Phase %0d saw %0d of %0d expected commits", phase + 1, idx, traceLen);
            haltErrs++;
        end
        reportTest($sformatf("halt, phase %0d", phase + 1), haltErrs);
        if (err !== flags[1]) begin
            $display("FAILED at %0d ns: err expected %0b, actual %0b", $time, flags[1], err);
            errErrs++;
        end
        if (flags[1] && errDropped) begin
            $display("The err flag went low again after it was raised");
            errErrs++;
        end
        if (!flags[1] && errEverHigh) begin
            $display("The err flag was raised although no illegal opcode should issue");
            errErrs++;
        end
        reportTest($sformatf("err flag, phase %0d", phase + 1), errErrs);
    endtask

    always @(negedge clk) begin
        if (reset) begin                // Fresh state for each phase
            idx = 0;
            curTest = 0;
            curErrs = 0;
            extraCommits = 0;
            lateCommits = 0;
            errEverHigh = 1'b0;
            errDropped = 1'b0;
        end else begin
            if (wbValid) begin
                checkCommit();
            end
            if (err) begin
                errEverHigh = 1'b1;
            end else if (errEverHigh) begin
                errDropped = 1'b1;      // Sticky flag fell
            end
            if (phaseDone) begin
                closePhase();
            end
        end
    end

endmodule

// File: test/procGolden.mem
// Golden image for procTb, 16-bit hex words, phase 1 at @00 and phase 2 at @80
// Per phase: progLen traceLen flags (bit0 halted, bit1 err), program words, rows of test reg data
@00
0025 000C 0001         // 37 words, 12 commits, halted set, err clear
// Test 1, pc 0-7
C105 C2FD 0000 0000    // LBI r1,5; LBI r2,-3; NOP; NOP
4102 42FF 0000 0000    // ADDI r1,2; ADDI r2,-1; NOP; NOP
// Test 2, pc 8-15
D94C D951 0000 0000    // ADD r3=r1+r2; SUB r4=r1-r2; NOP; NOP
DB96 DB9B 0000 0000    // AND r5=r3&r4; XOR r6=r3^r4; NOP; NOP
// Test 3, pc 16-19
8401 8B09 0000 0000    // ST r4 at r4+1; LD r3 from r3+9, same word 12
// Test 4, pc 20-33
6002 C111 C222         // BEQZ r0,+2 taken; two skipped LBIs
6B01 C133              // BNEZ r3,+1 taken; one skipped LBI
6305 C144              // BEQZ r3,+5 falls through; LBI r1,0x44
2002 C255 C266         // J +2; two skipped LBIs
3001 C277              // JAL +1 writes r7=31; skipped LBI
6801 C208              // BNEZ r0,+1 falls through; LBI r2,8
// Test 5, pc 34-36
0800 F800 C499         // HALT; illegal opcode and LBI never issue
// Expected commits
0001 0001 0005
0001 0002 FFFD
0001 0001 0007
0001 0002 FFFC
0002 0003 0003
0002 0004 000B
0002 0005 0003
0002 0006 0008
0003 0003 000B
0004 0001 0044
0004 0007 001F
0004 0002 0008
@80
0005 0002 0003         // 5 words, 2 commits, halted and err both set
C12A F800 0000 4101    // LBI r1,0x2A; illegal opcode; NOP; ADDI r1,1
0800                   // HALT
0006 0001 002A
0006 0001 002B

// File: test/procTb.sv
// Testbench top for the pipelined processor: loads each program phase from the golden image,
// runs it until halted, then lets procChecker close the phase and prints the final verdict
`timescale 1ns/100ps
module procTb
    import procIsaPkg::*;
();

    logic    clk;
    logic    reset;
    logic    imemWrite;
    pcT      imemAddr;
    wordT    imemData;
    logic    wbValid;
    regAddrT wbAddr;
    wordT    wbData;
    logic    halted;
    logic    err;
    int      phase;                  // 0 or 1, picks the golden section
    logic    phaseDone;
    logic    timedOut;
    int      testsRun;
    int      testsPassed;
    int      testsFailed;
    wordT    golden [imemDepth];     // Two phases of imemDepth/2 words each

    proc proc_i (
        .clk       (clk),
        .reset     (reset),
        .imemWrite (imemWrite),
        .imemAddr  (imemAddr),
        .imemData  (imemData),
        .wbValid   (wbValid),
        .wbAddr    (wbAddr),
        .wbData    (wbData),
        .halted    (halted),
        .err       (err)
    );

    procChecker procChecker_i (
        .clk         (clk),
        .reset       (reset),
        .wbValid     (wbValid),
        .wbAddr      (wbAddr),
        .wbData      (wbData),
        .halted      (halted),
        .err         (err),
        .phase       (phase),
        .phaseDone   (phaseDone),
        .golden      (golden),
        .testsRun    (testsRun),
        .testsPassed (testsPassed),
        .testsFailed (testsFailed)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;      // 100 ns period
    end

    // Reset spans the program load plus 5 cycles, then run until halted
    task automatic loadAndRun(input int p);
        int base;
        int progLen;
        int i;
        int cycles;
        base = p * (imemDepth / 2);
        progLen = int'(golden[base]);
        @(posedge clk);
        reset <= 1'b1;
        phase <= p;
        for (i = 0; i < progLen; i++) begin
            @(posedge clk);
            imemWrite <= 1'b1;
            imemAddr <= pcT'(i);
            imemData <= golden[base + 3 + i];   // Program follows the 3-word header
        end
        @(posedge clk);
        imemWrite <= 1'b0;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        cycles = 0;
        while (!halted && cycles < 2000) begin
            @(posedge clk);
            cycles++;
        end
        if (!halted) begin
            timedOut = 1'b1;
            $display("Processor never halted in phase %0d within 2000 cycles", p + 1);
        end else begin
            repeat (4) @(posedge clk);  // Window for stray commits after halt
        end
        phaseDone <= 1'b1;
        @(posedge clk);
        phaseDone <= 1'b0;
        @(posedge clk);                 // Checker closes the phase on the negedge between
    endtask

    initial begin
        reset = 1'b1;
        imemWrite = 1'b0;
        imemAddr = '0;
        imemData = '0;
        phase = 0;
        phaseDone = 1'b0;
        timedOut = 1'b0;
        $readmemh("test/procGolden.mem", golden);
        loadAndRun(0);
        if (!timedOut) begin
            loadAndRun(1);              // Illegal-opcode program after a fresh reset
        end
        $display("Tests run %0d, passed %0d, failed %0d", testsRun, testsPassed, testsFailed);
        if (!timedOut && testsFailed == 0 && testsRun > 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: verilog/decode.sv
// Decode stage: control decoder, immediate extension, register addressing
// Issues into the ID/EX register and flags illegal opcodes on the sticky err output
`timescale 1ns/100ps
`default_nettype none
module decode
    import procIsaPkg::*, procPipePkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  ifIdT    ifId,
    input  logic    redirect,       // Flush the word in decode
    output regAddrT rsAddr,
    output regAddrT rtAddr,
    input  wordT    rsVal,          // From regFile, same cycle
    input  wordT    rtVal,
    output idExT    idEx,
    output logic    err
);

    opcodeT  opcode;
    functT   funct;
    ctrlT    ctrl;
    wordT    imm8Ext;
    wordT    imm11Ext;
    wordT    imm;
    regAddrT wrAddr;
    logic    rType;
    logic    illegal;
    logic    stopped;               // HALT already issued
    logic    issue;

    assign opcode = opcodeT'(ifId.instr[opMsb:opLsb]);
    assign funct = functT'(ifId.instr[fnMsb:fnLsb]);
    assign imm8Ext = {{(dataWidth-imm8Msb-1){ifId.instr[imm8Msb]}}, ifId.instr[imm8Msb:0]};
    assign imm11Ext = {{(dataWidth-imm11Msb-1){ifId.instr[imm11Msb]}}, ifId.instr[imm11Msb:0]};

    always_comb begin
        ctrl = ctrlNop;
        imm = imm8Ext;
        wrAddr = ifId.instr[rsMsb:rsLsb];   // I-type writes its own register
        rType = 1'b0;
        illegal = 1'b0;
        case (opcode)
            OP_NOP:  ctrl = ctrlNop;
            OP_HALT: ctrl.halt = 1'b1;
            OP_ADDI: begin
                ctrl.useImm = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            OP_LBI: begin
                ctrl.aluOp = ALU_PASSB;
                ctrl.useImm = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            OP_ALU: begin
                rType = 1'b1;
                ctrl.regWrite = 1'b1;
                wrAddr = ifId.instr[rdMsb:rdLsb];
                case (funct)
                    FN_ADD: ctrl.aluOp = ALU_ADD;
                    FN_SUB: ctrl.aluOp = ALU_SUB;
                    FN_AND: ctrl.aluOp = ALU_AND;
                    FN_XOR: ctrl.aluOp = ALU_XOR;
                endcase
            end
            OP_LD: begin
                ctrl.useImm = 1'b1;         // Address is rs + imm
                ctrl.memRead = 1'b1;
                ctrl.wbSel = WB_MEM;
                ctrl.regWrite = 1'b1;
            end
            OP_ST: begin
                ctrl.useImm = 1'b1;
                ctrl.memWrite = 1'b1;
            end
            OP_BEQZ: ctrl.branchZero = 1'b1;
            OP_BNEZ: ctrl.branchNonZero = 1'b1;
            OP_J: begin
                ctrl.jump = 1'b1;
                imm = imm11Ext;
            end
            OP_JAL: begin
                ctrl.jump = 1'b1;
                ctrl.wbSel = WB_LINK;
                ctrl.regWrite = 1'b1;
                imm = imm11Ext;
                wrAddr = linkReg;
            end
            default: illegal = 1'b1;        // Goes down the pipe as a NOP
        endcase
    end

    assign rsAddr = ifId.instr[rsMsb:rsLsb];
    assign rtAddr = rType ? ifId.instr[rtMsb:rtLsb] : ifId.instr[rsMsb:rsLsb]; // ST data reg
    assign issue = ifId.valid && !redirect && !stopped;

    always_ff @(posedge clk) begin
        if (reset) begin
            idEx.valid <= 1'b0;
            stopped <= 1'b0;
            err <= 1'b0;
        end else begin
            idEx <= '{valid: issue, ctrl: ctrl, pc: ifId.pc, rsVal: rsVal, rtVal: rtVal,
                      imm: imm, wrAddr: wrAddr};
            stopped <= stopped | (issue && ctrl.halt);  // Nothing younger than HALT issues
            err <= err | (issue && illegal);            // Sticky until reset
        end
    end

endmodule
`default_nettype wire

// File: verilog/execute.sv
// Execute stage: ALU, branch and jump resolution, and the EX/MEM register
// Taken control flow raises redirect for one cycle and flushes fetch and decode
`timescale 1ns/100ps
`default_nettype none
module execute
    import procIsaPkg::*, procPipePkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  idExT  idEx,
    output logic  redirect,
    output pcT    redirectPc,
    output logic  haltSeen,         // Level, stays up until reset
    output exMemT exMem
);

    wordT opB;
    wordT aluOut;
    pcT   linkPc;
    logic rsZero;
    logic taken;

    assign opB = idEx.ctrl.useImm ? idEx.imm : idEx.rtVal;

    always_comb begin
        case (idEx.ctrl.aluOp)
            ALU_ADD: aluOut = idEx.rsVal + opB;    // Also LD/ST address
            ALU_SUB: aluOut = idEx.rsVal - opB;
            ALU_AND: aluOut = idEx.rsVal & opB;
            ALU_XOR: aluOut = idEx.rsVal ^ opB;
            default: aluOut = opB;                 // PASSB for LBI
        endcase
    end

    // Branch test on rs only
    assign rsZero = (idEx.rsVal == '0);
    assign taken = idEx.ctrl.jump
                 | (idEx.ctrl.branchZero & rsZero)
                 | (idEx.ctrl.branchNonZero & ~rsZero);

    assign linkPc = idEx.pc + pcT'(1);
    assign redirectPc = linkPc + idEx.imm[pcWidth-1:0];   // pc+1+imm, wraps in imem
    assign redirect = idEx.valid && taken;

    always_ff @(posedge clk) begin
        if (reset) begin
            haltSeen <= 1'b0;
            exMem.valid <= 1'b0;
        end else begin
            haltSeen <= haltSeen | (idEx.valid && idEx.ctrl.halt);
            exMem <= '{valid: idEx.valid, ctrl: idEx.ctrl, aluOut: aluOut,
                       storeData: idEx.rtVal, linkPc: linkPc, wrAddr: idEx.wrAddr};
        end
    end

endmodule
`default_nettype wire

// File: verilog/fetch.sv
// Fetch stage: PC, instruction memory with its load port, and the IF/ID register
// Program is written through imemWrite while reset is held
`timescale 1ns/100ps
`default_nettype none
module fetch
    import procIsaPkg::*, procPipePkg::*;
(
    input  logic clk,
    input  logic reset,
    input  logic imemWrite,         // Load strobe, only during reset
    input  pcT   imemAddr,
    input  wordT imemData,
    input  logic redirect,          // Taken branch or jump in execute
    input  pcT   redirectPc,
    input  logic haltSeen,          // HALT has left execute
    output ifIdT ifId
);

    wordT imem [imemDepth];
    pcT   pc;
    wordT instr;

    // Program load port
    always_ff @(posedge clk) begin
        if (reset && imemWrite) begin
            imem[imemAddr] <= imemData;
        end
    end

    assign instr = imem[pc];        // Asynchronous read

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
            ifId.valid <= 1'b0;
        end else begin
            ifId.instr <= instr;
            ifId.pc <= pc;
            if (redirect) begin
                pc <= redirectPc;   // Next cycle fetches the target
                ifId.valid <= 1'b0; // Drop the wrong-path word
            end else if (haltSeen) begin
                ifId.valid <= 1'b0; // Stopped, PC held
            end else begin
                pc <= pc + pcT'(1);
                ifId.valid <= 1'b1;
            end
        end
    end

endmodule
`default_nettype wire

// File: verilog/memoryStage.sv
// Memory and writeback stage: data memory, writeback select, commit to regFile
// Also raises halted once a HALT has gone through
`timescale 1ns/100ps
`default_nettype none
module memoryStage
    import procIsaPkg::*, procPipePkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  exMemT exMem,
    output wbT    wb,
    output logic  halted
);

    wordT dmem [dmemDepth];
    logic [dmemAddrWidth-1:0] memAddr;
    wordT readData;
    wordT wbData;

    assign memAddr = exMem.aluOut[dmemAddrWidth-1:0];

    always_ff @(posedge clk) begin
        if (exMem.valid && exMem.ctrl.memWrite) begin
            dmem[memAddr] <= exMem.storeData;
        end
    end

    assign readData = exMem.ctrl.memRead ? dmem[memAddr] : '0;   // Asynchronous read

    always_comb begin
        case (exMem.ctrl.wbSel)
            WB_MEM:  wbData = readData;
            WB_LINK: wbData = wordT'(exMem.linkPc);   // Zero-extended return address
            default: wbData = exMem.aluOut;
        endcase
    end

    assign wb = '{valid: exMem.valid && exMem.ctrl.regWrite, wrAddr: exMem.wrAddr, data: wbData};

    always_ff @(posedge clk) begin
        if (reset) begin
            halted <= 1'b0;
        end else if (exMem.valid && exMem.ctrl.halt) begin
            halted <= 1'b1;
        end
    end

endmodule
`default_nettype wire

// File: verilog/proc.sv
// Top level of the four-stage pipeline: fetch, decode with regFile, execute, memory
// Exports the commit port and the halted and err flags
`timescale 1ns/100ps
`default_nettype none
module proc
    import procIsaPkg::*, procPipePkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  logic    imemWrite,      // Program load, honoured during reset
    input  pcT      imemAddr,
    input  wordT    imemData,
    output logic    wbValid,        // One commit per cycle at most
    output regAddrT wbAddr,
    output wordT    wbData,
    output logic    halted,
    output logic    err             // Illegal opcode seen
);

    ifIdT    ifId;
    idExT    idEx;
    exMemT   exMem;
    wbT      wb;
    regAddrT rsAddr;
    regAddrT rtAddr;
    wordT    rsVal;
    wordT    rtVal;
    logic    redirect;
    pcT      redirectPc;
    logic    haltSeen;

    fetch fetch_i (
        .clk        (clk),
        .reset      (reset),
        .imemWrite  (imemWrite),
        .imemAddr   (imemAddr),
        .imemData   (imemData),
        .redirect   (redirect),
        .redirectPc (redirectPc),
        .haltSeen   (haltSeen),
        .ifId       (ifId)
    );

    decode decode_i (
        .clk      (clk),
        .reset    (reset),
        .ifId     (ifId),
        .redirect (redirect),
        .rsAddr   (rsAddr),
        .rtAddr   (rtAddr),
        .rsVal    (rsVal),
        .rtVal    (rtVal),
        .idEx     (idEx),
        .err      (err)
    );

    regFile regFile_i (
        .clk    (clk),
        .reset  (reset),
        .rsAddr (rsAddr),
        .rtAddr (rtAddr),
        .rsVal  (rsVal),
        .rtVal  (rtVal),
        .wb     (wb)
    );

    execute execute_i (
        .clk        (clk),
        .reset      (reset),
        .idEx       (idEx),
        .redirect   (redirect),
        .redirectPc (redirectPc),
        .haltSeen   (haltSeen),
        .exMem      (exMem)
    );

    memoryStage memoryStage_i (
        .clk    (clk),
        .reset  (reset),
        .exMem  (exMem),
        .wb     (wb),
        .halted (halted)
    );

    // Commit port
    assign wbValid = wb.valid;
    assign wbAddr = wb.wrAddr;
    assign wbData = wb.data;

endmodule
`default_nettype wire

// File: verilog/procIsaPkg.sv
// Instruction set of the 16-bit four-stage pipeline: opcodes, field positions, sizes
// R-type: op[15:11] rs[10:8] rt[7:5] rd[4:2] fn[1:0]
// I-type: op[15:11] r[10:8] imm8[7:0], r is source, destination and store data
package procIsaPkg;

    localparam int dataWidth = 16;
    localparam int regAddrWidth = 3;
    localparam int numRegs = 2 ** regAddrWidth;
    localparam int imemDepth = 256;
    localparam int dmemDepth = 256;
    localparam int pcWidth = $clog2(imemDepth);        // Word address into imem
    localparam int dmemAddrWidth = $clog2(dmemDepth);

    localparam logic [regAddrWidth-1:0] linkReg = 3'd7; // JAL destination

    // Instruction field positions
    localparam int opMsb = 15;
    localparam int opLsb = 11;
    localparam int rsMsb = 10;
    localparam int rsLsb = 8;
    localparam int rtMsb = 7;
    localparam int rtLsb = 5;
    localparam int rdMsb = 4;
    localparam int rdLsb = 2;
    localparam int fnMsb = 1;
    localparam int fnLsb = 0;
    localparam int imm8Msb = 7;                        // Immediates start at bit 0
    localparam int imm11Msb = 10;

    typedef logic [dataWidth-1:0] wordT;
    typedef logic [regAddrWidth-1:0] regAddrT;
    typedef logic [pcWidth-1:0] pcT;

    typedef enum logic [4:0] {
        OP_NOP  = 5'b00000,   // Empty imem reads as NOP
        OP_HALT = 5'b00001,
        OP_J    = 5'b00100,
        OP_JAL  = 5'b00110,
        OP_ADDI = 5'b01000,
        OP_BEQZ = 5'b01100,
        OP_BNEZ = 5'b01101,
        OP_ST   = 5'b10000,
        OP_LD   = 5'b10001,
        OP_LBI  = 5'b11000,
        OP_ALU  = 5'b11011    // Register-register group
    } opcodeT;

    typedef enum logic [1:0] {
        FN_ADD = 2'b00,
        FN_SUB = 2'b01,       // rs - rt
        FN_AND = 2'b10,
        FN_XOR = 2'b11
    } functT;

endpackage

// File: verilog/procPipePkg.sv
// Pipeline types: decoded control word and the registers between the stages
// Shared by all stages and the top level
package procPipePkg;

    import procIsaPkg::*;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_XOR,
        ALU_PASSB             // LBI, passes the immediate
    } aluOpT;

    typedef enum logic [1:0] {
        WB_ALU,
        WB_MEM,
        WB_LINK               // pc+1 for JAL
    } wbSelT;

    typedef struct packed {
        aluOpT aluOp;
        logic  useImm;        // Operand B is the immediate
        wbSelT wbSel;
        logic  regWrite;
        logic  memRead;
        logic  memWrite;
        logic  branchZero;
        logic  branchNonZero;
        logic  jump;          // J and JAL
        logic  halt;
    } ctrlT;

    localparam ctrlT ctrlNop = '{
        aluOp: ALU_ADD,
        useImm: 1'b0,
        wbSel: WB_ALU,
        regWrite: 1'b0,
        memRead: 1'b0,
        memWrite: 1'b0,
        branchZero: 1'b0,
        branchNonZero: 1'b0,
        jump: 1'b0,
        halt: 1'b0
    };

    typedef struct packed {
        logic valid;
        wordT instr;
        pcT   pc;
    } ifIdT;

    typedef struct packed {
        logic    valid;
        ctrlT    ctrl;
        pcT      pc;
        wordT    rsVal;
        wordT    rtVal;
        wordT    imm;         // Already sign-extended
        regAddrT wrAddr;
    } idExT;

    typedef struct packed {
        logic    valid;
        ctrlT    ctrl;
        wordT    aluOut;      // Result or memory address
        wordT    storeData;
        pcT      linkPc;
        regAddrT wrAddr;
    } exMemT;

    typedef struct packed {
        logic    valid;
        regAddrT wrAddr;
        wordT    data;
    } wbT;

endpackage

// File: verilog/regFile.sv
// Eight-entry register file, two combinational read ports and one write port
// A write in the current cycle is visible on the reads of that cycle
`timescale 1ns/100ps
`default_nettype none
module regFile
    import procIsaPkg::*, procPipePkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  regAddrT rsAddr,
    input  regAddrT rtAddr,
    output wordT    rsVal,
    output wordT    rtVal,
    input  wbT      wb              // Commit from memory stage
);

    wordT regs [numRegs];
    logic rsHit;
    logic rtHit;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < numRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.valid) begin
            regs[wb.wrAddr] <= wb.data;
        end
    end

    // Write-through bypass
    assign rsHit = wb.valid && (wb.wrAddr == rsAddr);
    assign rtHit = wb.valid && (wb.wrAddr == rtAddr);

    assign rsVal = rsHit ? wb.data : regs[rsAddr];
    assign rtVal = rtHit ? wb.data : regs[rtAddr];

endmodule
`default_nettype wire
